// File: bench/openfire_checker.sv
`timescale 1ns/1ps

module openfire_checker (
	input  logic                clock,
	input  logic                arst_n,
	input  logic                imem_re,
	input  logic                dmem_re,
	input  logic                dmem_we,
	input  openfire_pkg::addr_t dmem_addr,
	input  openfire_pkg::word_t dmem_data_out,
	input  logic                dmem_done,
	input  logic                end_of_run,
	output logic                stores_done,
	output logic                report_done,
	output int                  error_count
);

	string               exp_name [$];
	openfire_pkg::addr_t exp_addr [$];
	openfire_pkg::word_t exp_data [$];
	int   exp_count = 0;
	int   seen = 0;
	int   errors = 0;
	logic after_reset = 1'b0;	// first cycle after release.
	logic reported = 1'b0;

	task automatic expect_store(input string name, input openfire_pkg::addr_t addr,
			input openfire_pkg::word_t data);
		exp_name.push_back(name);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
	endtask

	// ************************************************
	// expected stores, in program order
	// ************************************************
	initial begin
		expect_store("reg add", 32'h0000_0200, 32'h2143_5777);
		expect_store("reg rsub", 32'h0000_0204, 32'hfcda_aa87);	// r3 - r2.
		expect_store("reg or", 32'h0000_0208, 32'h1f3f_56ff);
		expect_store("reg and", 32'h0000_020c, 32'h0204_0078);
		expect_store("reg xor", 32'h0000_0210, 32'h1d3b_5687);
		expect_store("addi neg", 32'h0000_0214, 32'h1234_5668);
		expect_store("rsubi neg", 32'h0000_0218, 32'hf0f0_ff00);
		expect_store("ori neg", 32'h0000_021c, 32'hffff_8001);
		expect_store("andi neg", 32'h0000_0220, 32'h1234_5070);
		expect_store("xori neg", 32'h0000_0224, 32'hf0f0_80ff);
		expect_store("r0 write", 32'h0000_0228, 32'h0000_0000);
		expect_store("bypass chain", 32'h0000_022c, 32'h0000_0060);	// 100 - 4.
		expect_store("lw sw reg", 32'h0000_0248, 32'h0000_0003);
		expect_store("lwi swi", 32'h0000_0240, 32'hffff_fff0);
		expect_store("store reload", 32'h0000_0244, 32'h2143_5777);
		expect_store("load use", 32'h0000_024c, 32'h2143_5778);
		expect_store("bnei not taken", 32'h0000_0258, 32'h0000_0060);
		expect_store("beqi not taken", 32'h0000_025c, 32'h0000_0003);
		expect_store("bnei taken", 32'h0000_0268, 32'h0f0f_00ff);
		exp_count = exp_name.size();
	end

	assign stores_done = (exp_count > 0) && (seen >= exp_count);
	assign report_done = reported;
	assign error_count = errors;

	always @(posedge clock) begin : compare
		int bad;
		bad = 0;
		after_reset <= !arst_n;
		if ((!arst_n || after_reset) && (dmem_re === 1'b1 || dmem_we === 1'b1)) begin
			$display("data memory was accessed during reset at %0t", $time);
			bad++;
		end
		if (!arst_n && imem_re === 1'b1) begin
			$display("instruction memory was read during reset at %0t", $time);
			bad++;
		end

		// one store completes per done pulse.
		if (arst_n && dmem_we === 1'b1 && dmem_done === 1'b1) begin
			if (seen >= exp_count) begin
				$display("extra store of %h to address %h after the expected sequence",
					dmem_data_out, dmem_addr);
				bad++;
			end else if (dmem_addr !== exp_addr[seen] || dmem_data_out !== exp_data[seen]) begin
				$display("error %s: expected %h at %h, actual %h at %h", exp_name[seen],
					exp_data[seen], exp_addr[seen], dmem_data_out, dmem_addr);
				bad++;
			end
			seen <= seen + 1;
		end

		if (end_of_run && !reported) begin
			if (seen < exp_count) begin
				$display("%0d expected store(s) never happened, the first one is %s",
					exp_count - seen, exp_name[seen]);
				bad++;
			end
			reported <= 1'b1;
		end
		errors <= errors + bad;
	end

endmodule

// File: bench/openfire_tb.sv
`timescale 1ns/1ps

module openfire_tb;

	localparam int imem_words = 64;
	localparam int dmem_words = 256;
	localparam int cycles_per_word = 12;	// watchdog budget.

	logic                clock;
	logic                arst_n = 1'b0;
	logic                imem_re;
	openfire_pkg::addr_t imem_addr;
	openfire_pkg::word_t imem_data_in = '0;
	logic                imem_done = 1'b0;
	logic                dmem_re;
	logic                dmem_we;
	openfire_pkg::addr_t dmem_addr;
	openfire_pkg::word_t dmem_data_out;
	openfire_pkg::word_t dmem_data_in = '0;
	logic                dmem_done = 1'b0;

	logic end_of_run = 1'b0;
	logic stores_done;
	logic report_done;
	int   error_count;

	openfire_pkg::word_t imem [imem_words];
	openfire_pkg::word_t dmem [dmem_words];
	logic        imem_busy = 1'b0;
	logic        dmem_busy = 1'b0;
	int unsigned imem_wait = 0;
	int unsigned dmem_wait = 0;
	integer      seed = 32'h46a2_7671;

	string               prog_name [$];
	openfire_pkg::word_t prog_word [$];
	int                  prog_len = 0;

	openfire_cpu dut0 (
		.clock         (clock),
		.arst_n        (arst_n),
		.imem_re       (imem_re),
		.imem_addr     (imem_addr),
		.imem_data_in  (imem_data_in),
		.imem_done     (imem_done),
		.dmem_re       (dmem_re),
		.dmem_we       (dmem_we),
		.dmem_addr     (dmem_addr),
		.dmem_data_out (dmem_data_out),
		.dmem_data_in  (dmem_data_in),
		.dmem_done     (dmem_done)
	);

	openfire_checker chk0 (
		.clock         (clock),
		.arst_n        (arst_n),
		.imem_re       (imem_re),
		.dmem_re       (dmem_re),
		.dmem_we       (dmem_we),
		.dmem_addr     (dmem_addr),
		.dmem_data_out (dmem_data_out),
		.dmem_done     (dmem_done),
		.end_of_run    (end_of_run),
		.stores_done   (stores_done),
		.report_done   (report_done),
		.error_count   (error_count)
	);

	function automatic openfire_pkg::word_t reg_form(input openfire_pkg::opcode_t op,
			input openfire_pkg::reg_addr_t rd, input openfire_pkg::reg_addr_t ra,
			input openfire_pkg::reg_addr_t rb);
		return {op, rd, ra, rb, 11'b0};
	endfunction

	function automatic openfire_pkg::word_t imm_form(input openfire_pkg::opcode_t op,
			input openfire_pkg::reg_addr_t rd, input openfire_pkg::reg_addr_t ra,
			input logic [15:0] imm);
		return {op, rd, ra, imm};
	endfunction

	task automatic add_row(input string name, input openfire_pkg::word_t word);
		prog_name.push_back(name);
		prog_word.push_back(word);
	endtask

	// ************************************************
	// program table
	// ************************************************
	task automatic build_program();
		add_row("setup", imm_form(openfire_pkg::op_addi, 1, 0, 16'h0100));
		add_row("setup", imm_form(openfire_pkg::op_lwi, 2, 1, 16'h0000));
		add_row("setup", imm_form(openfire_pkg::op_lwi, 3, 1, 16'h0004));
		add_row("setup", imm_form(openfire_pkg::op_addi, 10, 0, 16'h0200));
		add_row("reg add", reg_form(openfire_pkg::op_add, 4, 2, 3));
		add_row("reg add", imm_form(openfire_pkg::op_swi, 4, 10, 16'h0000));
		add_row("reg rsub", reg_form(openfire_pkg::op_rsub, 5, 2, 3));
		add_row("reg rsub", imm_form(openfire_pkg::op_swi, 5, 10, 16'h0004));
		add_row("reg or", reg_form(openfire_pkg::op_or, 6, 2, 3));
		add_row("reg or", imm_form(openfire_pkg::op_swi, 6, 10, 16'h0008));
		add_row("reg and", reg_form(openfire_pkg::op_and, 7, 2, 3));
		add_row("reg and", imm_form(openfire_pkg::op_swi, 7, 10, 16'h000c));
		add_row("reg xor", reg_form(openfire_pkg::op_xor, 8, 2, 3));
		add_row("reg xor", imm_form(openfire_pkg::op_swi, 8, 10, 16'h0010));
		add_row("addi neg", imm_form(openfire_pkg::op_addi, 4, 2, 16'hfff0));
		add_row("addi neg", imm_form(openfire_pkg::op_swi, 4, 10, 16'h0014));
		add_row("rsubi neg", imm_form(openfire_pkg::op_rsubi, 5, 3, 16'hffff));
		add_row("rsubi neg", imm_form(openfire_pkg::op_swi, 5, 10, 16'h0018));
		add_row("ori neg", imm_form(openfire_pkg::op_ori, 6, 0, 16'h8001));
		add_row("ori neg", imm_form(openfire_pkg::op_swi, 6, 10, 16'h001c));
		add_row("andi neg", imm_form(openfire_pkg::op_andi, 7, 2, 16'hf0f0));
		add_row("andi neg", imm_form(openfire_pkg::op_swi, 7, 10, 16'h0020));
		add_row("xori neg", imm_form(openfire_pkg::op_xori, 8, 3, 16'h8000));
		add_row("xori neg", imm_form(openfire_pkg::op_swi, 8, 10, 16'h0024));
		add_row("r0 write", imm_form(openfire_pkg::op_addi, 0, 2, 16'h0005));
		add_row("r0 write", imm_form(openfire_pkg::op_swi, 0, 10, 16'h0028));
		add_row("bypass chain", imm_form(openfire_pkg::op_addi, 9, 0, 16'h0001));
		add_row("bypass chain", reg_form(openfire_pkg::op_add, 9, 9, 9));
		add_row("bypass chain", reg_form(openfire_pkg::op_add, 9, 9, 9));
		add_row("bypass chain", imm_form(openfire_pkg::op_rsubi, 9, 9, 16'd100));
		add_row("bypass chain", imm_form(openfire_pkg::op_swi, 9, 10, 16'h002c));
		add_row("setup", imm_form(openfire_pkg::op_addi, 11, 0, 16'h0008));
		add_row("setup", imm_form(openfire_pkg::op_addi, 13, 0, 16'h0240));
		add_row("lw sw reg", reg_form(openfire_pkg::op_lw, 12, 1, 11));
		add_row("lw sw reg", reg_form(openfire_pkg::op_sw, 12, 13, 11));
		add_row("lwi swi", imm_form(openfire_pkg::op_lwi, 14, 1, 16'h000c));
		add_row("lwi swi", imm_form(openfire_pkg::op_swi, 14, 13, 16'h0000));
		add_row("store reload", imm_form(openfire_pkg::op_lwi, 15, 10, 16'h0000));
		add_row("store reload", imm_form(openfire_pkg::op_swi, 15, 13, 16'h0004));
		add_row("load use", imm_form(openfire_pkg::op_addi, 15, 15, 16'h0001));
		add_row("load use", imm_form(openfire_pkg::op_swi, 15, 13, 16'h000c));
		add_row("bri taken", imm_form(openfire_pkg::op_bri, 0, 0, 16'h0008));
		add_row("bri shadow", imm_form(openfire_pkg::op_swi, 2, 13, 16'h0010));
		add_row("beqi taken", imm_form(openfire_pkg::op_bcci, 0, 0, 16'h0008));
		add_row("beqi shadow", imm_form(openfire_pkg::op_swi, 2, 13, 16'h0014));
		add_row("bnei not taken", imm_form(openfire_pkg::op_bcci, 1, 0, 16'h0008));
		add_row("bnei not taken", imm_form(openfire_pkg::op_swi, 9, 13, 16'h0018));
		add_row("beqi not taken", imm_form(openfire_pkg::op_bcci, 0, 9, 16'h0008));
		add_row("beqi not taken", imm_form(openfire_pkg::op_swi, 12, 13, 16'h001c));
		add_row("bnei taken", imm_form(openfire_pkg::op_bcci, 1, 9, 16'h000c));
		add_row("bnei shadow", imm_form(openfire_pkg::op_swi, 2, 13, 16'h0020));
		add_row("bnei shadow", imm_form(openfire_pkg::op_swi, 3, 13, 16'h0024));
		add_row("bnei taken", imm_form(openfire_pkg::op_swi, 3, 13, 16'h0028));
		add_row("halt", imm_form(openfire_pkg::op_bri, 0, 0, 16'h0000));	// spins here.
	endtask

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// ************************************************
	// memory models
	// ************************************************
	always @(posedge clock) begin
		if (!arst_n) begin
			imem_done <= 1'b0;
			imem_busy <= 1'b0;
			dmem_done <= 1'b0;
			dmem_busy <= 1'b0;
		end else begin
			imem_done <= 1'b0;	// one-cycle pulse.
			if (imem_busy) begin
				if (imem_wait == 0) begin
					imem_done    <= 1'b1;
					imem_data_in <= imem[imem_addr[7:2]];
					imem_busy    <= 1'b0;
				end else
					imem_wait <= imem_wait - 1;
			end else if (imem_re && !imem_done) begin
				imem_busy <= 1'b1;
				imem_wait <= $unsigned($random(seed)) % 4;	// 1 to 4 cycles.
			end

			dmem_done <= 1'b0;
			if (dmem_busy) begin
				if (dmem_wait == 0) begin
					dmem_done <= 1'b1;
					dmem_busy <= 1'b0;
					if (dmem_we)
						dmem[dmem_addr[9:2]] <= dmem_data_out;
					else
						dmem_data_in <= dmem[dmem_addr[9:2]];
				end else
					dmem_wait <= dmem_wait - 1;
			end else if ((dmem_re || dmem_we) && !dmem_done) begin
				dmem_busy <= 1'b1;
				dmem_wait <= $unsigned($random(seed)) % 4;
			end
		end
	end

	initial begin
		int waited;
		int run_limit;
		build_program();
		for (int i = 0; i < imem_words; i++)
			imem[i] = '0;	// add r0, r0, r0 does nothing.
		for (int i = 0; i < prog_word.size(); i++)
			imem[i] = prog_word[i];
		for (int i = 0; i < dmem_words; i++)
			dmem[i] = (i * 4) ^ 32'hc3c3_0000;	// follows the byte address.
		dmem[64] = 32'h1234_5678;	// 0x100.
		dmem[65] = 32'h0f0f_00ff;
		dmem[66] = 32'h0000_0003;
		dmem[67] = 32'hffff_fff0;
		prog_len = prog_word.size();
		run_limit = (prog_len + 4) * cycles_per_word;	// ends ahead of the watchdog.
		waited = 0;

		repeat (3) @(posedge clock);
		arst_n <= 1'b1;
		while (!stores_done && waited < run_limit) begin
			@(posedge clock);
			waited++;
		end
		repeat (16) @(posedge clock);	// catches stray stores.
		end_of_run <= 1'b1;
		do
			@(posedge clock);
		while (!report_done);

		$display("run complete with %0d error(s)", error_count);
		if (error_count == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

	// ************************************************
	// watchdog
	// ************************************************
	initial begin
		int limit;
		wait (prog_len != 0);
		limit = (prog_len + 8) * cycles_per_word;
		repeat (limit) @(posedge clock);
		$display("timeout after %0d cycles with %0d error(s), fetch stuck at pc %h (%s)",
			limit, error_count, imem_addr,
			(imem_addr[31:2] < prog_len) ? prog_name[imem_addr[31:2]] : "outside the program");
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// File: hw/openfire_cpu.sv
`timescale 1ns/1ps

module openfire_cpu (
	input  logic                clock,
	input  logic                arst_n,

	// instruction port.
	output logic                imem_re,
	output openfire_pkg::addr_t imem_addr,
	input  openfire_pkg::word_t imem_data_in,
	input  logic                imem_done,

	// data port.
	output logic                dmem_re,
	output logic                dmem_we,
	output openfire_pkg::addr_t dmem_addr,
	output openfire_pkg::word_t dmem_data_out,
	input  openfire_pkg::word_t dmem_data_in,
	input  logic                dmem_done
);

	fetch_if    fetch_bus ();
	issue_if    issue_bus ();
	reg_read_if rf_bus ();

	logic                    wb_we;
	openfire_pkg::reg_addr_t wb_addr;
	openfire_pkg::word_t     wb_data;
	logic                    redirect;	// taken branch.
	openfire_pkg::addr_t     redirect_pc;

	// ************************************************
	// pipeline
	// ************************************************
	openfire_fetch fetch0 (
		.clock        (clock),
		.arst_n       (arst_n),
		.imem_re      (imem_re),
		.imem_addr    (imem_addr),
		.imem_data_in (imem_data_in),
		.imem_done    (imem_done),
		.redirect     (redirect),
		.redirect_pc  (redirect_pc),
		.fetch        (fetch_bus.master)
	);

	openfire_decode decode0 (
		.clock    (clock),
		.arst_n   (arst_n),
		.fetch    (fetch_bus.slave),
		.issue    (issue_bus.master),
		.rf       (rf_bus.requester),
		.redirect (redirect)
	);

	openfire_execute execute0 (
		.clock         (clock),
		.arst_n        (arst_n),
		.issue         (issue_bus.slave),
		.wb_we         (wb_we),
		.wb_addr       (wb_addr),
		.wb_data       (wb_data),
		.redirect      (redirect),
		.redirect_pc   (redirect_pc),
		.dmem_re       (dmem_re),
		.dmem_we       (dmem_we),
		.dmem_addr     (dmem_addr),
		.dmem_data_out (dmem_data_out),
		.dmem_data_in  (dmem_data_in),
		.dmem_done     (dmem_done)
	);

	openfire_regfile regfile0 (
		.clock   (clock),
		.arst_n  (arst_n),
		.rf      (rf_bus.responder),
		.wb_we   (wb_we),
		.wb_addr (wb_addr),
		.wb_data (wb_data)
	);

endmodule

// File: hw/openfire_decode.sv
`timescale 1ns/1ps

module openfire_decode (
	input  logic          clock,
	input  logic          arst_n,
	fetch_if.slave        fetch,
	issue_if.master       issue,
	reg_read_if.requester rf,
	input  logic          redirect
);

	openfire_pkg::opcode_t   opcode;
	openfire_pkg::reg_addr_t rd_f;
	openfire_pkg::reg_addr_t ra_f;
	openfire_pkg::reg_addr_t rb_f;
	openfire_pkg::word_t     imm_ext;

	// decoded, before the issue register.
	openfire_pkg::alu_fn_t   fn_d;
	logic                    use_imm_d;
	logic                    is_load_d;
	logic                    is_store_d;
	logic                    is_branch_d;
	logic                    cond_ne_d;
	openfire_pkg::reg_addr_t rd_d;
	openfire_pkg::reg_addr_t ra_d;

	// ************************************************
	// issue register
	// ************************************************
	logic                    valid_q;
	openfire_pkg::alu_fn_t   fn_q;
	logic                    use_imm_q;
	logic                    is_load_q;
	logic                    is_store_q;
	logic                    is_branch_q;
	logic                    cond_ne_q;
	openfire_pkg::word_t     imm_q;
	openfire_pkg::addr_t     pc_q;
	openfire_pkg::reg_addr_t rd_q;
	openfire_pkg::reg_addr_t ra_q;
	openfire_pkg::reg_addr_t rb_q;
	logic take;

	assign opcode  = fetch.instr[31:26];
	assign rd_f    = fetch.instr[25:21];
	assign ra_f    = fetch.instr[20:16];
	assign rb_f    = fetch.instr[15:11];
	assign imm_ext = {{16{fetch.instr[15]}}, fetch.instr[15:0]};

	always_comb begin
		fn_d        = openfire_pkg::fn_add;
		use_imm_d   = 1'b0;
		is_load_d   = 1'b0;
		is_store_d  = 1'b0;
		is_branch_d = 1'b0;
		cond_ne_d   = 1'b0;
		rd_d        = rd_f;
		ra_d        = ra_f;
		case (opcode)
			openfire_pkg::op_add:  fn_d = openfire_pkg::fn_add;
			openfire_pkg::op_rsub: fn_d = openfire_pkg::fn_rsub;
			openfire_pkg::op_or:   fn_d = openfire_pkg::fn_or;
			openfire_pkg::op_and:  fn_d = openfire_pkg::fn_and;
			openfire_pkg::op_xor:  fn_d = openfire_pkg::fn_xor;
			openfire_pkg::op_addi: use_imm_d = 1'b1;
			openfire_pkg::op_rsubi: begin
				fn_d      = openfire_pkg::fn_rsub;
				use_imm_d = 1'b1;
			end
			openfire_pkg::op_ori: begin
				fn_d      = openfire_pkg::fn_or;
				use_imm_d = 1'b1;
			end
			openfire_pkg::op_andi: begin
				fn_d      = openfire_pkg::fn_and;
				use_imm_d = 1'b1;
			end
			openfire_pkg::op_xori: begin
				fn_d      = openfire_pkg::fn_xor;
				use_imm_d = 1'b1;
			end
			openfire_pkg::op_lw:   is_load_d = 1'b1;
			openfire_pkg::op_lwi: begin
				is_load_d = 1'b1;
				use_imm_d = 1'b1;
			end
			openfire_pkg::op_sw:   is_store_d = 1'b1;	// rd carries the store data.
			openfire_pkg::op_swi: begin
				is_store_d = 1'b1;
				use_imm_d  = 1'b1;
			end
			openfire_pkg::op_bri: begin
				// beq on r0, so always taken.
				is_branch_d = 1'b1;
				ra_d        = '0;
				rd_d        = '0;
			end
			openfire_pkg::op_bcci: begin
				is_branch_d = 1'b1;
				cond_ne_d   = (rd_f == 5'd1);
				rd_d        = '0;
			end
			default: rd_d = '0;	// no-op into r0.
		endcase
	end

	assign take        = fetch.valid && fetch.ready;
	assign fetch.ready = !valid_q || issue.ready;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n)
			valid_q <= 1'b0;
		else if (redirect)
			valid_q <= 1'b0;	// wrong path.
		else if (take)
			valid_q <= 1'b1;
		else if (issue.ready)
			valid_q <= 1'b0;
	end

	always_ff @(posedge clock) begin
		if (take) begin
			fn_q        <= fn_d;
			use_imm_q   <= use_imm_d;
			is_load_q   <= is_load_d;
			is_store_q  <= is_store_d;
			is_branch_q <= is_branch_d;
			cond_ne_q   <= cond_ne_d;
			imm_q       <= imm_ext;
			pc_q        <= fetch.pc;
			rd_q        <= rd_d;
			ra_q        <= ra_d;
			rb_q        <= rb_f;
		end
	end

	// operands come straight from the register file at issue time.
	assign rf.ra_addr = ra_q;
	assign rf.rb_addr = rb_q;
	assign rf.rd_addr = rd_q;

	assign issue.valid      = valid_q;
	assign issue.fn         = fn_q;
	assign issue.use_imm    = use_imm_q;
	assign issue.is_load    = is_load_q;
	assign issue.is_store   = is_store_q;
	assign issue.is_branch  = is_branch_q;
	assign issue.cond_ne    = cond_ne_q;
	assign issue.op_a       = rf.ra_data;
	assign issue.op_b       = rf.rb_data;
	assign issue.store_data = rf.rd_data;
	assign issue.imm        = imm_q;
	assign issue.pc         = pc_q;
	assign issue.rd         = rd_q;

endmodule

// File: hw/openfire_execute.sv
`timescale 1ns/1ps

module openfire_execute (
	input  logic                    clock,
	input  logic                    arst_n,
	issue_if.slave                  issue,
	output logic                    wb_we,
	output openfire_pkg::reg_addr_t wb_addr,
	output openfire_pkg::word_t     wb_data,
	output logic                    redirect,
	output openfire_pkg::addr_t     redirect_pc,
	output logic                    dmem_re,
	output logic                    dmem_we,
	output openfire_pkg::addr_t     dmem_addr,
	output openfire_pkg::word_t     dmem_data_out,
	input  openfire_pkg::word_t     dmem_data_in,
	input  logic                    dmem_done
);

	openfire_pkg::exe_state_e state;
	openfire_pkg::word_t alu_b;
	openfire_pkg::word_t sum;
	openfire_pkg::word_t alu_res;
	logic sub;
	logic zero;
	logic taken;
	logic mem_op;
	logic accept;
	logic mem_done;

	logic alu_we_q;
	logic load_q;
	openfire_pkg::word_t result_q;
	openfire_pkg::reg_addr_t rd_q;

	// ************************************************
	// alu
	// ************************************************
	assign alu_b = issue.use_imm ? issue.imm : issue.op_b;
	assign sub   = (issue.fn == openfire_pkg::fn_rsub);

	// b - a as b + ~a + 1, also the load/store address adder.
	assign sum = alu_b + (issue.op_a ^ {openfire_pkg::data_w{sub}})
		+ openfire_pkg::word_t'(sub);

	always_comb begin
		case (issue.fn)
			openfire_pkg::fn_or:  alu_res = issue.op_a | alu_b;
			openfire_pkg::fn_and: alu_res = issue.op_a & alu_b;
			openfire_pkg::fn_xor: alu_res = issue.op_a ^ alu_b;
			default:              alu_res = sum;	// add, rsub.
		endcase
	end

	// branch test on ra.
	assign zero  = (issue.op_a == '0);
	assign taken = issue.is_branch && (issue.cond_ne ? !zero : zero);

	// ************************************************
	// control
	// ************************************************
	assign mem_op   = issue.is_load || issue.is_store;
	assign mem_done = (state == openfire_pkg::e_mem) && dmem_done;
	// hold off while the redirect flushes the wrong-path instruction.
	assign issue.ready = ((state == openfire_pkg::e_idle) && !redirect) || mem_done;
	assign accept      = issue.valid && issue.ready;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state    <= openfire_pkg::e_idle;
			alu_we_q <= 1'b0;
			redirect <= 1'b0;
		end else begin
			alu_we_q <= 1'b0;	// one-cycle pulses.
			redirect <= 1'b0;
			if (mem_done)
				state <= openfire_pkg::e_idle;
			if (accept) begin
				if (mem_op)
					state <= openfire_pkg::e_mem;
				alu_we_q <= !mem_op && !issue.is_branch && (issue.rd != '0);
				redirect <= taken;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			result_q      <= alu_res;
			rd_q          <= issue.rd;
			load_q        <= issue.is_load;
			redirect_pc   <= issue.pc + issue.imm;
			dmem_addr     <= sum;
			dmem_data_out <= issue.store_data;
		end
	end

	assign dmem_re = (state == openfire_pkg::e_mem) && load_q;
	assign dmem_we = (state == openfire_pkg::e_mem) && !load_q;

	// load data is written in the done cycle.
	assign wb_we   = alu_we_q || (mem_done && load_q && (rd_q != '0));
	assign wb_addr = rd_q;
	assign wb_data = (state == openfire_pkg::e_mem) ? dmem_data_in : result_q;

endmodule

// File: hw/openfire_fetch.sv
`timescale 1ns/1ps

module openfire_fetch (
	input  logic                clock,
	input  logic                arst_n,
	output logic                imem_re,
	output openfire_pkg::addr_t imem_addr,
	input  openfire_pkg::word_t imem_data_in,
	input  logic                imem_done,
	input  logic                redirect,
	input  openfire_pkg::addr_t redirect_pc,
	fetch_if.master             fetch
);

	openfire_pkg::fetch_state_e state;
	openfire_pkg::addr_t pc;	// address of the current or next request.
	openfire_pkg::addr_t pend_pc;	// branch target waiting for a stale reply.
	logic drop;
	openfire_pkg::word_t instr_q;
	openfire_pkg::addr_t pc_q;
	logic accepted;

	assign imem_re   = (state == openfire_pkg::f_wait);
	assign imem_addr = pc;
	assign accepted  = fetch.valid && fetch.ready;

	assign fetch.valid = (state == openfire_pkg::f_full);
	assign fetch.instr = instr_q;
	assign fetch.pc    = pc_q;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state <= openfire_pkg::f_idle;
			pc    <= openfire_pkg::reset_pc;
			drop  <= 1'b0;
		end else begin
			case (state)
				openfire_pkg::f_idle: begin
					state <= openfire_pkg::f_wait;
					if (redirect)
						pc <= redirect_pc;
				end
				openfire_pkg::f_wait: begin
					if (imem_done) begin
						drop <= 1'b0;
						if (redirect)
							pc <= redirect_pc;	// reply is stale, refetch.
						else if (drop)
							pc <= pend_pc;
						else begin
							pc    <= pc + 32'd4;
							state <= openfire_pkg::f_full;
						end
					end else if (redirect)
						drop <= 1'b1;	// request must still finish.
				end
				openfire_pkg::f_full: begin
					if (redirect) begin
						pc    <= redirect_pc;
						state <= openfire_pkg::f_wait;
					end else if (accepted)
						state <= openfire_pkg::f_wait;
				end
				default: state <= openfire_pkg::f_idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (redirect)
			pend_pc <= redirect_pc;
		if (state == openfire_pkg::f_wait && imem_done) begin
			instr_q <= imem_data_in;
			pc_q    <= pc;
		end
	end

endmodule

// File: hw/openfire_if.sv
`timescale 1ns/1ps

// fetch buffer to decode register.
interface fetch_if;
	logic                valid;
	logic                ready;
	openfire_pkg::word_t instr;
	openfire_pkg::addr_t pc;

	modport master (output valid, output instr, output pc, input ready);
	modport slave (input valid, input instr, input pc, output ready);
endinterface

// decode register to execute.
interface issue_if;
	logic                      valid;
	logic                      ready;
	openfire_pkg::alu_fn_t     fn;
	logic                      use_imm;
	logic                      is_load;
	logic                      is_store;
	logic                      is_branch;
	logic                      cond_ne;
	openfire_pkg::word_t       op_a;
	openfire_pkg::word_t       op_b;
	openfire_pkg::word_t       store_data;
	openfire_pkg::word_t       imm;
	openfire_pkg::addr_t       pc;
	openfire_pkg::reg_addr_t   rd;

	modport master (
		output valid, fn, use_imm, is_load, is_store, is_branch, cond_ne,
		output op_a, op_b, store_data, imm, pc, rd,
		input ready
	);
	modport slave (
		input valid, fn, use_imm, is_load, is_store, is_branch, cond_ne,
		input op_a, op_b, store_data, imm, pc, rd,
		output ready
	);
endinterface

// three async read ports.
interface reg_read_if;
	openfire_pkg::reg_addr_t ra_addr;
	openfire_pkg::reg_addr_t rb_addr;
	openfire_pkg::reg_addr_t rd_addr;
	openfire_pkg::word_t     ra_data;
	openfire_pkg::word_t     rb_data;
	openfire_pkg::word_t     rd_data;

	modport requester (output ra_addr, rb_addr, rd_addr, input ra_data, rb_data, rd_data);
	modport responder (input ra_addr, rb_addr, rd_addr, output ra_data, rb_data, rd_data);
endinterface

// File: hw/openfire_pkg.sv
package openfire_pkg;

	// ************************************************
	// widths
	// ************************************************
	localparam int data_w   = 32;
	localparam int addr_w   = 32;
	localparam int reg_w    = 5;
	localparam int opcode_w = 6;
	localparam int fn_w     = 3;
	localparam int reg_count = 32;	// r0 included.

	typedef logic [data_w-1:0]   word_t;
	typedef logic [addr_w-1:0]   addr_t;
	typedef logic [reg_w-1:0]    reg_addr_t;
	typedef logic [opcode_w-1:0] opcode_t;
	typedef logic [fn_w-1:0]     alu_fn_t;

	// ************************************************
	// primary opcodes, microblaze encoding
	// ************************************************
	localparam opcode_t op_add   = 6'b000000;
	localparam opcode_t op_rsub  = 6'b000001;
	localparam opcode_t op_or    = 6'b100000;
	localparam opcode_t op_and   = 6'b100001;
	localparam opcode_t op_xor   = 6'b100010;

	localparam opcode_t op_addi  = 6'b001000;
	localparam opcode_t op_rsubi = 6'b001001;
	localparam opcode_t op_ori   = 6'b101000;
	localparam opcode_t op_andi  = 6'b101001;
	localparam opcode_t op_xori  = 6'b101010;

	localparam opcode_t op_lw    = 6'b110010;
	localparam opcode_t op_sw    = 6'b110110;
	localparam opcode_t op_lwi   = 6'b111010;
	localparam opcode_t op_swi   = 6'b111110;

	localparam opcode_t op_bri   = 6'b101110;
	localparam opcode_t op_bcci  = 6'b101111;	// rd field picks eq/ne.

	// alu functions.
	localparam alu_fn_t fn_add  = 3'd0;
	localparam alu_fn_t fn_rsub = 3'd1;
	localparam alu_fn_t fn_or   = 3'd2;
	localparam alu_fn_t fn_and  = 3'd3;
	localparam alu_fn_t fn_xor  = 3'd4;

	localparam addr_t reset_pc = '0;

	// ************************************************
	// state machines
	// ************************************************
	typedef enum logic [1:0] {
		f_idle,
		f_wait,
		f_full
	} fetch_state_e;

	typedef enum logic {
		e_idle,
		e_mem
	} exe_state_e;

endpackage

// File: hw/openfire_regfile.sv
`timescale 1ns/1ps

module openfire_regfile (
	input  logic                    clock,
	input  logic                    arst_n,
	reg_read_if.responder           rf,
	input  logic                    wb_we,
	input  openfire_pkg::reg_addr_t wb_addr,
	input  openfire_pkg::word_t     wb_data
);

	openfire_pkg::word_t regs [openfire_pkg::reg_count];

	// async read with write-through of this cycle's result.
	function automatic openfire_pkg::word_t read_port(input openfire_pkg::reg_addr_t a);
		if (wb_we && (wb_addr == a) && (a != '0))
			return wb_data;
		return regs[a];
	endfunction

	always_comb begin
		rf.ra_data = read_port(rf.ra_addr);
		rf.rb_data = read_port(rf.rb_addr);
		rf.rd_data = read_port(rf.rd_addr);
	end

	// ************************************************
	// write-back
	// ************************************************
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < openfire_pkg::reg_count; i++)
				regs[i] <= '0;
		end else if (wb_we && (wb_addr != '0)) begin
			regs[wb_addr] <= wb_data;	// r0 stays zero.
		end
	end

endmodule

// File: openfire_cpu.f
hw/openfire_pkg.sv
hw/openfire_if.sv
hw/openfire_fetch.sv
hw/openfire_decode.sv
hw/openfire_execute.sv
hw/openfire_regfile.sv
hw/openfire_cpu.sv
bench/openfire_checker.sv
bench/openfire_tb.sv
